// File: Makefile
VERILATOR := verilator
VFLAGS    := --binary --timing --timescale 1ns/1ps -j 0
TOP       := tb_itch_decoder
FILELIST  := list.f
OBJ_DIR   := obj_dir
LOG       := sim.log

SIM     := $(OBJ_DIR)/V$(TOP)
SOURCES := $(filter %.sv %.v,$(shell cat $(FILELIST)))
HEADERS := $(wildcard design/*.svh)

.PHONY: all run clean

all: run

$(SIM): $(FILELIST) $(SOURCES) $(HEADERS)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(SIM)
	./$(SIM) | tee $(LOG)
	@grep -qF '*** TEST PASSED ***' $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// File: design/itch_consts.svh
`ifndef ITCH_CONSTS_SVH
`define ITCH_CONSTS_SVH

// MoldUDP64 payload word and byte
`define ITCH_WORD_W 64
`define ITCH_BYTE_W 8

// message store, longest kept type is add order
`define ITCH_WORDS 5
`define ITCH_BUF_W 320

// word counter, saturates at 7
`define ITCH_CNT_W 3

// ASCII message type codes
`define ITCH_TYPE_SYSTEM_EVENT   83
`define ITCH_TYPE_ADD_ORDER      65
`define ITCH_TYPE_ORDER_EXECUTED 69
`define ITCH_TYPE_ORDER_CANCEL   88
`define ITCH_TYPE_ORDER_DELETE   68

// payload words per message type
`define ITCH_LEN_SYSTEM_EVENT   2
`define ITCH_LEN_ADD_ORDER      5
`define ITCH_LEN_ORDER_EXECUTED 4
`define ITCH_LEN_ORDER_CANCEL   3
`define ITCH_LEN_ORDER_DELETE   3

`endif

// File: design/itch_decoder.sv
`timescale 1ns/1ps
`default_nettype none

`include "itch_consts.svh"

module itch_decoder
	import itch_pkg::*;
(
	input  wire logic                    clk,
	input  wire logic                    nreset,
	input  wire logic                    mold_v_i,
	input  wire logic                    mold_start_i,
	input  wire logic [`ITCH_WORD_W-1:0] mold_data_i,

	output logic                         system_event_v_o,
	output logic                         add_order_v_o,
	output logic                         order_executed_v_o,
	output logic                         order_cancel_v_o,
	output logic                         order_delete_v_o,

	output logic [2*`ITCH_BYTE_W-1:0]    stock_locate_o,
	output logic [2*`ITCH_BYTE_W-1:0]    tracking_number_o,
	output logic [6*`ITCH_BYTE_W-1:0]    timestamp_o,
	output logic [`ITCH_BYTE_W-1:0]      event_code_o,
	output logic [8*`ITCH_BYTE_W-1:0]    order_reference_number_o,
	output logic [`ITCH_BYTE_W-1:0]      buy_sell_indicator_o,
	output logic [4*`ITCH_BYTE_W-1:0]    shares_o,
	output logic [8*`ITCH_BYTE_W-1:0]    stock_o,
	output logic [4*`ITCH_BYTE_W-1:0]    price_o,
	output logic [8*`ITCH_BYTE_W-1:0]    match_number_o
);

	logic [`ITCH_WORDS-1:0] wr_en;
	itch_msg_u              msg;
	itch_kind_t             kind;

	itch_msg_ctrl u_itch_msg_ctrl (
		.clk          (clk),
		.nreset       (nreset),
		.mold_v_i     (mold_v_i),
		.mold_start_i (mold_start_i),
		.msg_type_i   (msg.system_event.msg_type),
		.wr_en_o      (wr_en),
		.kind_o       (kind)
	);

	itch_word_buffer u_itch_word_buffer (
		.clk         (clk),
		.mold_data_i (mold_data_i),
		.wr_en_i     (wr_en),
		.msg_o       (msg)
	);

	itch_field_mux u_itch_field_mux (
		.msg_i                    (msg),
		.kind_i                   (kind),
		.stock_locate_o           (stock_locate_o),
		.tracking_number_o        (tracking_number_o),
		.timestamp_o              (timestamp_o),
		.event_code_o             (event_code_o),
		.order_reference_number_o (order_reference_number_o),
		.buy_sell_indicator_o     (buy_sell_indicator_o),
		.shares_o                 (shares_o),
		.stock_o                  (stock_o),
		.price_o                  (price_o),
		.match_number_o           (match_number_o)
	);

	// valids are levels straight from the kind decode
	assign system_event_v_o   = kind.system_event;
	assign add_order_v_o      = kind.add_order;
	assign order_executed_v_o = kind.order_executed;
	assign order_cancel_v_o   = kind.order_cancel;
	assign order_delete_v_o   = kind.order_delete;

endmodule

`default_nettype wire

// File: design/itch_field_mux.sv
`timescale 1ns/1ps
`default_nettype none

`include "itch_consts.svh"

module itch_field_mux
	import itch_pkg::*;
(
	input  itch_msg_u                         msg_i,
	input  itch_kind_t                        kind_i,
	output logic [2*`ITCH_BYTE_W-1:0]         stock_locate_o,
	output logic [2*`ITCH_BYTE_W-1:0]         tracking_number_o,
	output logic [6*`ITCH_BYTE_W-1:0]         timestamp_o,
	output logic [`ITCH_BYTE_W-1:0]           event_code_o,
	output logic [8*`ITCH_BYTE_W-1:0]         order_reference_number_o,
	output logic [`ITCH_BYTE_W-1:0]           buy_sell_indicator_o,
	output logic [4*`ITCH_BYTE_W-1:0]         shares_o,
	output logic [8*`ITCH_BYTE_W-1:0]         stock_o,
	output logic [4*`ITCH_BYTE_W-1:0]         price_o,
	output logic [8*`ITCH_BYTE_W-1:0]         match_number_o
);

	// header is the same for every type
	assign stock_locate_o    = msg_i.system_event.stock_locate;
	assign tracking_number_o = msg_i.system_event.tracking_number;
	assign timestamp_o       = msg_i.system_event.timestamp;

	assign event_code_o = msg_i.system_event.event_code;

	// same offset in all four order views
	assign order_reference_number_o = msg_i.order_delete.order_reference_number;

	assign buy_sell_indicator_o = msg_i.add_order.buy_sell_indicator;
	assign stock_o              = msg_i.add_order.stock;
	assign price_o              = msg_i.add_order.price;

	assign match_number_o = msg_i.order_executed.match_number;

	// share count moves between byte 19 and byte 20
	always_comb begin
		if (kind_i.order_executed || kind_i.order_cancel) begin
			// executed and cancelled shares both start at byte 19
			shares_o = msg_i.order_executed.executed_shares;
		end else begin
			shares_o = msg_i.add_order.shares;
		end
	end

endmodule

`default_nettype wire

// File: design/itch_msg_ctrl.sv
`timescale 1ns/1ps
`default_nettype none

`include "itch_consts.svh"

module itch_msg_ctrl
	import itch_pkg::*;
(
	input  wire logic                     clk,
	input  wire logic                     nreset,
	input  wire logic                     mold_v_i,
	input  wire logic                     mold_start_i,
	input  wire logic [`ITCH_BYTE_W-1:0]  msg_type_i,
	output logic      [`ITCH_WORDS-1:0]   wr_en_o,
	output itch_kind_t                    kind_o
);

	logic [`ITCH_CNT_W-1:0] cnt_q;
	logic                   start_v;

	assign start_v = mold_start_i & mold_v_i;

	// words received so far in the current message
	always_ff @(posedge clk) begin
		if (nreset) begin
			cnt_q <= '0;
		end else if (start_v) begin
			cnt_q <= `ITCH_CNT_W'(1);
		end else if (mold_v_i && (cnt_q != '1)) begin
			cnt_q <= cnt_q + `ITCH_CNT_W'(1);
		end
	end

	assign wr_en_o[0] = start_v;

	// word i lands while the counter reads i
	genvar i;
	generate
		for (i = 1; i < `ITCH_WORDS; i++) begin : g_wr_en
			assign wr_en_o[i] = mold_v_i & ~mold_start_i & (cnt_q == `ITCH_CNT_W'(i));
		end
	endgenerate

	// complete only while the count matches the type length exactly
	assign kind_o.system_event =
		(msg_type_i == `ITCH_BYTE_W'(`ITCH_TYPE_SYSTEM_EVENT)) &&
		(cnt_q == `ITCH_CNT_W'(`ITCH_LEN_SYSTEM_EVENT));

	assign kind_o.add_order =
		(msg_type_i == `ITCH_BYTE_W'(`ITCH_TYPE_ADD_ORDER)) &&
		(cnt_q == `ITCH_CNT_W'(`ITCH_LEN_ADD_ORDER));

	assign kind_o.order_executed =
		(msg_type_i == `ITCH_BYTE_W'(`ITCH_TYPE_ORDER_EXECUTED)) &&
		(cnt_q == `ITCH_CNT_W'(`ITCH_LEN_ORDER_EXECUTED));

	assign kind_o.order_cancel =
		(msg_type_i == `ITCH_BYTE_W'(`ITCH_TYPE_ORDER_CANCEL)) &&
		(cnt_q == `ITCH_CNT_W'(`ITCH_LEN_ORDER_CANCEL));

	assign kind_o.order_delete =
		(msg_type_i == `ITCH_BYTE_W'(`ITCH_TYPE_ORDER_DELETE)) &&
		(cnt_q == `ITCH_CNT_W'(`ITCH_LEN_ORDER_DELETE));

endmodule

`default_nettype wire

// File: design/itch_pkg.sv
`default_nettype none

`include "itch_consts.svh"

package itch_pkg;

	// fields are declared msb first, so the type byte sits at bits 7:0
	typedef struct packed {
		logic [`ITCH_BUF_W-12*`ITCH_BYTE_W-1:0] reserved;
		logic [`ITCH_BYTE_W-1:0]                event_code;
		logic [6*`ITCH_BYTE_W-1:0]              timestamp;
		logic [2*`ITCH_BYTE_W-1:0]              tracking_number;
		logic [2*`ITCH_BYTE_W-1:0]              stock_locate;
		logic [`ITCH_BYTE_W-1:0]                msg_type;
	} itch_system_event_t;

	// 36 bytes
	typedef struct packed {
		logic [`ITCH_BUF_W-36*`ITCH_BYTE_W-1:0] reserved;
		logic [4*`ITCH_BYTE_W-1:0]              price;
		logic [8*`ITCH_BYTE_W-1:0]              stock;
		logic [4*`ITCH_BYTE_W-1:0]              shares;
		logic [`ITCH_BYTE_W-1:0]                buy_sell_indicator;
		logic [8*`ITCH_BYTE_W-1:0]              order_reference_number;
		logic [6*`ITCH_BYTE_W-1:0]              timestamp;
		logic [2*`ITCH_BYTE_W-1:0]              tracking_number;
		logic [2*`ITCH_BYTE_W-1:0]              stock_locate;
		logic [`ITCH_BYTE_W-1:0]                msg_type;
	} itch_add_order_t;

	// 31 bytes
	typedef struct packed {
		logic [`ITCH_BUF_W-31*`ITCH_BYTE_W-1:0] reserved;
		logic [8*`ITCH_BYTE_W-1:0]              match_number;
		logic [4*`ITCH_BYTE_W-1:0]              executed_shares;
		logic [8*`ITCH_BYTE_W-1:0]              order_reference_number;
		logic [6*`ITCH_BYTE_W-1:0]              timestamp;
		logic [2*`ITCH_BYTE_W-1:0]              tracking_number;
		logic [2*`ITCH_BYTE_W-1:0]              stock_locate;
		logic [`ITCH_BYTE_W-1:0]                msg_type;
	} itch_order_executed_t;

	// 23 bytes
	typedef struct packed {
		logic [`ITCH_BUF_W-23*`ITCH_BYTE_W-1:0] reserved;
		logic [4*`ITCH_BYTE_W-1:0]              cancelled_shares;
		logic [8*`ITCH_BYTE_W-1:0]              order_reference_number;
		logic [6*`ITCH_BYTE_W-1:0]              timestamp;
		logic [2*`ITCH_BYTE_W-1:0]              tracking_number;
		logic [2*`ITCH_BYTE_W-1:0]              stock_locate;
		logic [`ITCH_BYTE_W-1:0]                msg_type;
	} itch_order_cancel_t;

	// 19 bytes
	typedef struct packed {
		logic [`ITCH_BUF_W-19*`ITCH_BYTE_W-1:0] reserved;
		logic [8*`ITCH_BYTE_W-1:0]              order_reference_number;
		logic [6*`ITCH_BYTE_W-1:0]              timestamp;
		logic [2*`ITCH_BYTE_W-1:0]              tracking_number;
		logic [2*`ITCH_BYTE_W-1:0]              stock_locate;
		logic [`ITCH_BYTE_W-1:0]                msg_type;
	} itch_order_delete_t;

	// one buffer, five readings of it
	typedef union packed {
		itch_system_event_t   system_event;
		itch_add_order_t      add_order;
		itch_order_executed_t order_executed;
		itch_order_cancel_t   order_cancel;
		itch_order_delete_t   order_delete;
	} itch_msg_u;

	// completed message, at most one bit set
	typedef struct packed {
		logic order_delete;
		logic order_cancel;
		logic order_executed;
		logic add_order;
		logic system_event;
	} itch_kind_t;

endpackage

`default_nettype wire

// File: design/itch_word_buffer.sv
`timescale 1ns/1ps
`default_nettype none

`include "itch_consts.svh"

module itch_word_buffer
	import itch_pkg::*;
(
	input  wire logic                    clk,
	input  wire logic [`ITCH_WORD_W-1:0] mold_data_i,
	input  wire logic [`ITCH_WORDS-1:0]  wr_en_i,
	output itch_msg_u                    msg_o
);

	// word 0 in the low bits, so byte k is at bits 8k+7:8k
	logic [`ITCH_WORDS-1:0][`ITCH_WORD_W-1:0] words_q;

	genvar i;
	generate
		for (i = 0; i < `ITCH_WORDS; i++) begin : g_word
			always_ff @(posedge clk) begin
				if (wr_en_i[i]) begin
					words_q[i] <= mold_data_i;
				end
			end
		end
	endgenerate

	assign msg_o = words_q;

endmodule

`default_nettype wire

// File: list.f
+incdir+design
design/itch_pkg.sv
design/itch_msg_ctrl.sv
design/itch_word_buffer.sv
design/itch_field_mux.sv
design/itch_decoder.sv
test/tb_clk_gen.sv
test/tb_itch_decoder.sv

// File: test/tb_clk_gen.sv
`timescale 1ns/1ps
`default_nettype none

module tb_clk_gen (
	output logic clk_o,
	output logic nreset_o
);

	// 20 ns period
	initial begin
		clk_o = 1'b0;
		forever #10 clk_o = ~clk_o;
	end

	// reset is active high, released just after the 16th rising edge
	initial begin
		nreset_o = 1'b1;
		repeat (16) @(posedge clk_o);
		#1 nreset_o = 1'b0;
	end

endmodule

`default_nettype wire

// File: test/tb_itch_decoder.sv
`timescale 1ns/1ps
`default_nettype none

`include "itch_consts.svh"

module tb_itch_decoder;

	// the whole run needs a few hundred cycles
	localparam int MAX_CYCLES = 2000;
	localparam int MAX_BYTES  = 80;

	logic        clk;
	logic        nreset;
	logic        mold_v;
	logic        mold_start;
	logic [63:0] mold_data;

	logic        system_event_v;
	logic        add_order_v;
	logic        order_executed_v;
	logic        order_cancel_v;
	logic        order_delete_v;
	logic [15:0] stock_locate;
	logic [15:0] tracking_number;
	logic [47:0] timestamp;
	logic [7:0]  event_code;
	logic [63:0] order_reference_number;
	logic [7:0]  buy_sell_indicator;
	logic [31:0] shares;
	logic [63:0] stock;
	logic [31:0] price;
	logic [63:0] match_number;

	integer      seed;
	logic [7:0]  cur_bytes [0:MAX_BYTES-1];
	logic [7:0]  ref_bytes [0:MAX_BYTES-1];
	// bit 0 system event, 1 add order, 2 executed, 3 cancel, 4 delete
	logic [4:0]  next_exp_kind;
	logic [4:0]  exp_kind;
	int          checks = 0;
	int          errors = 0;
	int          cycle_cnt = 0;
	int          test_errs;

	tb_clk_gen u_tb_clk_gen (
		.clk_o    (clk),
		.nreset_o (nreset)
	);

	itch_decoder u_itch_decoder (
		.clk                      (clk),
		.nreset                   (nreset),
		.mold_v_i                 (mold_v),
		.mold_start_i             (mold_start),
		.mold_data_i              (mold_data),
		.system_event_v_o         (system_event_v),
		.add_order_v_o            (add_order_v),
		.order_executed_v_o       (order_executed_v),
		.order_cancel_v_o         (order_cancel_v),
		.order_delete_v_o         (order_delete_v),
		.stock_locate_o           (stock_locate),
		.tracking_number_o        (tracking_number),
		.timestamp_o              (timestamp),
		.event_code_o             (event_code),
		.order_reference_number_o (order_reference_number),
		.buy_sell_indicator_o     (buy_sell_indicator),
		.shares_o                 (shares),
		.stock_o                  (stock),
		.price_o                  (price),
		.match_number_o           (match_number)
	);

	function automatic logic [4:0] kind_of(input logic [7:0] t);
		case (t)
			8'(`ITCH_TYPE_SYSTEM_EVENT):   return 5'b00001;
			8'(`ITCH_TYPE_ADD_ORDER):      return 5'b00010;
			8'(`ITCH_TYPE_ORDER_EXECUTED): return 5'b00100;
			8'(`ITCH_TYPE_ORDER_CANCEL):   return 5'b01000;
			8'(`ITCH_TYPE_ORDER_DELETE):   return 5'b10000;
			default:                       return 5'b00000;
		endcase
	endfunction

	function automatic int words_of(input logic [7:0] t);
		case (t)
			8'(`ITCH_TYPE_SYSTEM_EVENT):   return `ITCH_LEN_SYSTEM_EVENT;
			8'(`ITCH_TYPE_ADD_ORDER):      return `ITCH_LEN_ADD_ORDER;
			8'(`ITCH_TYPE_ORDER_EXECUTED): return `ITCH_LEN_ORDER_EXECUTED;
			8'(`ITCH_TYPE_ORDER_CANCEL):   return `ITCH_LEN_ORDER_CANCEL;
			8'(`ITCH_TYPE_ORDER_DELETE):   return `ITCH_LEN_ORDER_DELETE;
			default:                       return 0;
		endcase
	endfunction

	// expected field from nbytes little-endian bytes at message byte off
	function automatic logic [63:0] ref_field(input int off, input int nbytes);
		logic [63:0] v;
		v = '0;
		for (int j = 0; j < nbytes; j++) begin
			v[8*j +: 8] = ref_bytes[off + j];
		end
		return v;
	endfunction

	task automatic check_value(input string name, input logic [63:0] expected,
			input logic [63:0] actual);
		checks++;
		if (actual !== expected) begin
			errors++;
			$display("[FAIL] %0t ns %s expected %h got %h", $time, name, expected, actual);
		end
	endtask

	task automatic pick_type(output logic [7:0] t);
		int sel;
		sel = int'($unsigned($random(seed)) % 32'd5);
		case (sel)
			0:       t = 8'(`ITCH_TYPE_SYSTEM_EVENT);
			1:       t = 8'(`ITCH_TYPE_ADD_ORDER);
			2:       t = 8'(`ITCH_TYPE_ORDER_EXECUTED);
			3:       t = 8'(`ITCH_TYPE_ORDER_CANCEL);
			default: t = 8'(`ITCH_TYPE_ORDER_DELETE);
		endcase
	endtask

	task automatic idle_cycles(input int n);
		mold_v     = 1'b0;
		mold_start = 1'b0;
		repeat (n) begin
			// garbage on the data bus while idle
			mold_data = {$random(seed), $random(seed)};
			@(posedge clk);
			#1;
		end
	endtask

	task automatic drive_word(input int w, input logic start, input logic [4:0] kind_after);
		logic [63:0] word;
		for (int j = 0; j < 8; j++) begin
			word[8*j +: 8] = cur_bytes[8*w + j];
		end
		mold_v        = 1'b1;
		mold_start    = start;
		mold_data     = word;
		next_exp_kind = kind_after;
		@(posedge clk);
		#1;
		mold_v     = 1'b0;
		mold_start = 1'b0;
	endtask

	// random bytes with the type forced, sent as nwords words with gaps up to max_gap
	task automatic send_msg(input logic [7:0] t, input int nwords, input int max_gap);
		int gap;
		logic [4:0] kind_after;
		for (int i = 0; i < MAX_BYTES; i++) begin
			cur_bytes[i] = 8'($random(seed));
		end
		cur_bytes[0] = t;
		for (int w = 0; w < nwords; w++) begin
			if (w > 0 && max_gap > 0) begin
				gap = int'($unsigned($random(seed)) % 32'(max_gap + 1));
				idle_cycles(gap);
			end
			kind_after = (w + 1 == words_of(t)) ? kind_of(t) : 5'b00000;
			drive_word(w, (w == 0), kind_after);
		end
	endtask

	task automatic report_test(input string name, input int errs_before);
		if (errors == errs_before) begin
			$display("test %s: ok", name);
		end else begin
			$display("test %s: %0d errors", name, errors - errs_before);
		end
	endtask

	// expected valids follow accepted words only
	always @(posedge clk) begin
		if (nreset) begin
			exp_kind <= '0;
		end else if (mold_v) begin
			exp_kind <= next_exp_kind;
			if (next_exp_kind != 5'b00000) begin
				ref_bytes <= cur_bytes;
			end
		end
	end

	// compare on the falling edge where outputs are settled
	always @(negedge clk) begin
		if (cycle_cnt > 0) begin
			check_value("system_event_v_o", 64'(exp_kind[0]), 64'(system_event_v));
			check_value("add_order_v_o", 64'(exp_kind[1]), 64'(add_order_v));
			check_value("order_executed_v_o", 64'(exp_kind[2]), 64'(order_executed_v));
			check_value("order_cancel_v_o", 64'(exp_kind[3]), 64'(order_cancel_v));
			check_value("order_delete_v_o", 64'(exp_kind[4]), 64'(order_delete_v));
			if (exp_kind != 5'b00000) begin
				check_value("stock_locate_o", ref_field(1, 2), 64'(stock_locate));
				check_value("tracking_number_o", ref_field(3, 2), 64'(tracking_number));
				check_value("timestamp_o", ref_field(5, 6), 64'(timestamp));
				if (exp_kind != 5'b00001) begin
					check_value("order_reference_number_o", ref_field(11, 8),
						order_reference_number);
				end
			end
			case (exp_kind)
				5'b00001: begin
					check_value("event_code_o", ref_field(11, 1), 64'(event_code));
				end
				5'b00010: begin
					check_value("buy_sell_indicator_o", ref_field(19, 1),
						64'(buy_sell_indicator));
					check_value("shares_o", ref_field(20, 4), 64'(shares));
					check_value("stock_o", ref_field(24, 8), stock);
					check_value("price_o", ref_field(32, 4), 64'(price));
				end
				5'b00100: begin
					check_value("shares_o", ref_field(19, 4), 64'(shares));
					check_value("match_number_o", ref_field(23, 8), match_number);
				end
				5'b01000: begin
					check_value("shares_o", ref_field(19, 4), 64'(shares));
				end
				default: begin
				end
			endcase
		end
	end

	always @(posedge clk) begin
		cycle_cnt <= cycle_cnt + 1;
		if (cycle_cnt >= MAX_CYCLES) begin
			$display("timeout: run did not finish within %0d cycles", MAX_CYCLES);
			$display("*** TEST FAILED ***");
			$finish;
		end
	end

	initial begin
		logic [7:0] t;
		seed          = 32'h2f56705e;
		mold_v        = 1'b0;
		mold_start    = 1'b0;
		mold_data     = '0;
		next_exp_kind = '0;

		@(negedge nreset);
		@(posedge clk);
		#1;
		idle_cycles(4);
		report_test("1 reset", 0);

		test_errs = errors;
		send_msg(8'(`ITCH_TYPE_SYSTEM_EVENT), `ITCH_LEN_SYSTEM_EVENT, 0);
		idle_cycles(2);
		send_msg(8'(`ITCH_TYPE_ADD_ORDER), `ITCH_LEN_ADD_ORDER, 0);
		idle_cycles(2);
		send_msg(8'(`ITCH_TYPE_ORDER_EXECUTED), `ITCH_LEN_ORDER_EXECUTED, 0);
		idle_cycles(2);
		send_msg(8'(`ITCH_TYPE_ORDER_CANCEL), `ITCH_LEN_ORDER_CANCEL, 0);
		idle_cycles(2);
		send_msg(8'(`ITCH_TYPE_ORDER_DELETE), `ITCH_LEN_ORDER_DELETE, 0);
		idle_cycles(2);
		report_test("2 each type", test_errs);

		test_errs = errors;
		for (int n = 0; n < 12; n++) begin
			pick_type(t);
			send_msg(t, words_of(t), 3);
			idle_cycles(1);
		end
		idle_cycles(2);
		report_test("3 idle gaps", test_errs);

		// no idle between messages
		test_errs = errors;
		for (int n = 0; n < 20; n++) begin
			pick_type(t);
			send_msg(t, words_of(t), 0);
		end
		idle_cycles(2);
		report_test("4 back to back", test_errs);

		test_errs = errors;
		send_msg(8'h00, 5, 0);
		send_msg(8'h51, 3, 1);
		send_msg(8'h46, 2, 0);
		idle_cycles(2);
		send_msg(8'(`ITCH_TYPE_SYSTEM_EVENT), `ITCH_LEN_SYSTEM_EVENT + 1, 0);
		send_msg(8'(`ITCH_TYPE_ADD_ORDER), `ITCH_LEN_ADD_ORDER + 1, 0);
		send_msg(8'(`ITCH_TYPE_ORDER_EXECUTED), `ITCH_LEN_ORDER_EXECUTED + 1, 1);
		send_msg(8'(`ITCH_TYPE_ORDER_CANCEL), `ITCH_LEN_ORDER_CANCEL + 1, 0);
		send_msg(8'(`ITCH_TYPE_ORDER_DELETE), `ITCH_LEN_ORDER_DELETE + 1, 0);
		// counter runs into saturation long enough that a wrap would reach two again
		send_msg(8'(`ITCH_TYPE_SYSTEM_EVENT), 10, 1);
		idle_cycles(2);
		report_test("5 unknown and overlong", test_errs);

		$display("checks: %0d, errors: %0d", checks, errors);
		if (errors == 0) begin
			$display("*** TEST PASSED ***");
		end else begin
			$display("*** TEST FAILED ***");
		end
		$finish;
	end

endmodule

`default_nettype wire
